//--- src/pon_bridge_pkg.sv
package pon_bridge_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // link level types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;       // one link word, both paths
    typedef logic [15:0] frame_len_t;  // payload length in words
    typedef logic [15:0] seq_t;        // downstream frame counter

    // stream beat as stored in the FIFOs
    typedef struct packed {
        word_t data;
        logic  last;   // final word of a frame
    } beat_t;

    // second word of every PON burst
    typedef struct packed {
        seq_t       seq;   // upper half
        frame_len_t len;   // lower half, payload words only
    } pon_hdr_t;

    ////////////////////////////////////////////////////////////////////////////
    // protocol constants
    ////////////////////////////////////////////////////////////////////////////

    // burst preamble, matched with a bit error allowance on receive
    localparam word_t SYNC_WORD = 32'h0556_0556;

    // a burst on the wire looks like
    //   SYNC_WORD
    //   pon_hdr_t  {seq, len}
    //   len payload words
    // with no gap needed between bursts

endpackage

//--- src/axis_fifo.sv
module axis_fifo
    import pon_bridge_pkg::*;
#(
    parameter type payload_t = beat_t,  // beats or frame lengths
    parameter int  DEPTH     = 512
) (
    input  logic     axis_clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];   // storage array
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;         // entries held
    logic             wr_en;
    logic             rd_en;

    assign in_ready  = (count != CNT_W'(DEPTH));  // low while full
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];               // head of queue
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at DEPTH which need not be a power of two
    always_ff @(posedge axis_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push+pop
            endcase
        end
    end

    // a write on full or a read on empty pushes count out of 0..DEPTH
    assert property (@(posedge axis_clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

    // pointers meet only when empty or full
    assert property (@(posedge axis_clk) disable iff (rst)
        (wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(DEPTH))));

endmodule

//--- src/pon_frame_builder.sv
module pon_frame_builder
    import pon_bridge_pkg::*;
#(
    parameter int FIFO_DEPTH      = 512,
    parameter int MAX_FRAME_WORDS = 256
) (
    input  logic  axis_clk,
    input  logic  rst,
    input  word_t eth_rx_data,
    input  logic  eth_rx_last,
    input  logic  eth_rx_valid,
    output logic  eth_rx_ready,
    output word_t pon_tx_data,
    output logic  pon_tx_valid,
    input  logic  pon_tx_ready
);

    typedef enum logic [1:0] {S_IDLE, S_SYNC, S_HDR, S_PAYLOAD} tx_state_t;

    // ethernet side
    beat_t      rx_beat;
    logic       rx_acc;          // beat taken this cycle
    logic       dat_in_valid;
    logic       dat_in_ready;
    logic       len_in_valid;
    logic       len_in_ready;
    frame_len_t rx_cnt;          // words so far in open frame
    frame_len_t rx_len;          // count including current beat

    // pon side
    tx_state_t  state;
    beat_t      dat_out;
    logic       dat_out_valid;
    logic       dat_out_ready;
    frame_len_t len_out;
    logic       len_out_valid;
    logic       len_out_ready;
    frame_len_t tx_left;         // payload words still to send
    seq_t       seq;
    pon_hdr_t   hdr;

    ////////////////////////////////////////////////////////////////////////////
    // store side, frames are counted while they fill the data FIFO
    ////////////////////////////////////////////////////////////////////////////

    assign rx_beat      = '{data: eth_rx_data, last: eth_rx_last};
    assign eth_rx_ready = dat_in_ready && len_in_ready;  // hold off if no length slot
    assign dat_in_valid = eth_rx_valid && len_in_ready;
    assign rx_acc       = eth_rx_valid && eth_rx_ready;
    assign rx_len       = rx_cnt + 1'b1;
    assign len_in_valid = rx_acc && eth_rx_last;  // frame complete

    always_ff @(posedge axis_clk) begin
        if (rst) begin
            rx_cnt <= '0;
        end else if (rx_acc) begin
            rx_cnt <= eth_rx_last ? '0 : rx_len;
        end
    end

    axis_fifo #(
        .payload_t (beat_t),
        .DEPTH     (FIFO_DEPTH)
    ) data_fifo (
        .axis_clk  (axis_clk),
        .rst       (rst),
        .in_data   (rx_beat),
        .in_valid  (dat_in_valid),
        .in_ready  (dat_in_ready),
        .out_data  (dat_out),
        .out_valid (dat_out_valid),
        .out_ready (dat_out_ready)
    );

    axis_fifo #(
        .payload_t (frame_len_t),
        .DEPTH     (FIFO_DEPTH)
    ) len_fifo (
        .axis_clk  (axis_clk),
        .rst       (rst),
        .in_data   (rx_len),
        .in_valid  (len_in_valid),
        .in_ready  (len_in_ready),
        .out_data  (len_out),
        .out_valid (len_out_valid),
        .out_ready (len_out_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // send side: sync, header, payload
    ////////////////////////////////////////////////////////////////////////////

    assign hdr           = '{seq: seq, len: len_out};
    assign len_out_ready = (state == S_HDR) && pon_tx_ready;  // pop with header
    assign dat_out_ready = (state == S_PAYLOAD) && pon_tx_ready;

    always_ff @(posedge axis_clk) begin
        if (rst) begin
            state   <= S_IDLE;
            seq     <= '0;
            tx_left <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (len_out_valid) begin  // whole frame stored
                        state <= S_SYNC;
                    end
                end
                S_SYNC: begin
                    if (pon_tx_ready) begin
                        state <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (pon_tx_ready) begin
                        tx_left <= len_out;
                        state   <= S_PAYLOAD;
                    end
                end
                default: begin  // S_PAYLOAD
                    if (dat_out_valid && pon_tx_ready) begin
                        tx_left <= tx_left - 1'b1;
                        if (tx_left == 16'd1) begin
                            state <= S_IDLE;
                            seq   <= seq + 1'b1;  // next burst number
                        end
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            S_SYNC: begin
                pon_tx_valid = 1'b1;
                pon_tx_data  = SYNC_WORD;
            end
            S_HDR: begin
                pon_tx_valid = 1'b1;
                pon_tx_data  = hdr;
            end
            S_PAYLOAD: begin
                pon_tx_valid = dat_out_valid;
                pon_tx_data  = dat_out.data;
            end
            default: begin
                pon_tx_valid = 1'b0;
                pon_tx_data  = '0;
            end
        endcase
    end

    // oversized frames would overrun the header length field's meaning
    assert property (@(posedge axis_clk) disable iff (rst)
        rx_acc |-> rx_cnt < frame_len_t'(MAX_FRAME_WORDS));

    // stored last flag lines up with the queued length
    assert property (@(posedge axis_clk) disable iff (rst)
        dat_out_valid && dat_out_ready |-> dat_out.last == (tx_left == 16'd1));

endmodule

//--- src/pon_frame_sync.sv
module pon_frame_sync
    import pon_bridge_pkg::*;
#(
    parameter int SYNC_THRESHOLD  = 5,
    parameter int MAX_FRAME_WORDS = 256
) (
    input  logic  axis_clk,
    input  logic  rst,
    input  word_t pon_rx_data,
    input  logic  pon_rx_valid,
    output beat_t out_data,
    output logic  out_valid,
    input  logic  out_ready,
    output logic  sync_overflow
);

    typedef enum logic [1:0] {S_HUNT, S_HDR, S_PAYLOAD} rx_state_t;

    rx_state_t  state;
    logic [5:0] diff_bits;   // 0..32 bits off the sync word
    logic       sync_hit;
    pon_hdr_t   hdr;
    logic       hdr_ok;      // length in 1..MAX_FRAME_WORDS
    frame_len_t rx_left;     // payload words still expected
    logic       pay_word;    // payload word on the line now

    ////////////////////////////////////////////////////////////////////////////
    // sync word match with bit error allowance
    ////////////////////////////////////////////////////////////////////////////

    assign diff_bits = 6'($countones(pon_rx_data ^ SYNC_WORD));
    assign sync_hit  = (diff_bits <= 6'(SYNC_THRESHOLD));

    // seq in the header is carried but not checked
    assign hdr      = pon_hdr_t'(pon_rx_data);
    assign hdr_ok   = (hdr.len != '0) && (hdr.len <= frame_len_t'(MAX_FRAME_WORDS));
    assign pay_word = pon_rx_valid && (state == S_PAYLOAD);

    // state moves on valid words only as the line has no ready
    always_ff @(posedge axis_clk) begin
        if (rst) begin
            state   <= S_HUNT;
            rx_left <= '0;
        end else if (pon_rx_valid) begin
            case (state)
                S_HUNT: begin
                    if (sync_hit) begin
                        state <= S_HDR;
                    end
                end
                S_HDR: begin
                    rx_left <= hdr.len;
                    state   <= hdr_ok ? S_PAYLOAD : S_HUNT;  // bad length hunts again
                end
                S_PAYLOAD: begin
                    rx_left <= rx_left - 1'b1;
                    if (rx_left == 16'd1) begin
                        state <= S_HUNT;
                    end
                end
                default: begin
                    state <= S_HUNT;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // payload push into the upstream FIFO
    ////////////////////////////////////////////////////////////////////////////

    // one cycle after arrival
    always_ff @(posedge axis_clk) begin
        if (pay_word) begin
            out_data <= '{data: pon_rx_data, last: (rx_left == 16'd1)};
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rst) begin
            out_valid     <= 1'b0;
            sync_overflow <= 1'b0;
        end else begin
            out_valid <= pay_word;  // single cycle push strobe
            if (out_valid && !out_ready) begin
                sync_overflow <= 1'b1;  // word dropped and flag held
            end
        end
    end

    // sticky until reset
    assert property (@(posedge axis_clk)
        $fell(sync_overflow) |-> $past(rst));

    // remaining count stays within a legal frame while payload runs
    assert property (@(posedge axis_clk) disable iff (rst)
        state == S_PAYLOAD |-> (rx_left != '0) && (rx_left <= frame_len_t'(MAX_FRAME_WORDS)));

endmodule

//--- src/pon_bridge_top.sv
module pon_bridge_top
    import pon_bridge_pkg::*;
#(
    parameter int FIFO_DEPTH      = 512,
    parameter int MAX_FRAME_WORDS = 256,
    parameter int SYNC_THRESHOLD  = 5
) (
    input  logic  axis_clk,
    input  logic  rst,

    // ethernet receive, downstream source
    input  word_t eth_rx_data,
    input  logic  eth_rx_last,
    input  logic  eth_rx_valid,
    output logic  eth_rx_ready,

    // pon transmit
    output word_t pon_tx_data,
    output logic  pon_tx_valid,
    input  logic  pon_tx_ready,

    // pon receive, no back-pressure possible
    input  word_t pon_rx_data,
    input  logic  pon_rx_valid,

    // ethernet transmit, upstream sink
    output word_t eth_tx_data,
    output logic  eth_tx_last,
    output logic  eth_tx_valid,
    input  logic  eth_tx_ready,

    output logic  sync_overflow   // sticky drop flag
);

    // sync to upstream FIFO
    beat_t sync_beat;
    logic  sync_valid;
    logic  sync_ready;

    ////////////////////////////////////////////////////////////////////////////
    // downstream, ethernet to pon
    ////////////////////////////////////////////////////////////////////////////

    pon_frame_builder #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_FRAME_WORDS (MAX_FRAME_WORDS)
    ) frame_builder (
        .axis_clk     (axis_clk),
        .rst          (rst),
        .eth_rx_data  (eth_rx_data),
        .eth_rx_last  (eth_rx_last),
        .eth_rx_valid (eth_rx_valid),
        .eth_rx_ready (eth_rx_ready),
        .pon_tx_data  (pon_tx_data),
        .pon_tx_valid (pon_tx_valid),
        .pon_tx_ready (pon_tx_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // upstream, pon to ethernet
    ////////////////////////////////////////////////////////////////////////////

    pon_frame_sync #(
        .SYNC_THRESHOLD  (SYNC_THRESHOLD),
        .MAX_FRAME_WORDS (MAX_FRAME_WORDS)
    ) frame_sync (
        .axis_clk      (axis_clk),
        .rst           (rst),
        .pon_rx_data   (pon_rx_data),
        .pon_rx_valid  (pon_rx_valid),
        .out_data      (sync_beat),
        .out_valid     (sync_valid),
        .out_ready     (sync_ready),
        .sync_overflow (sync_overflow)
    );

    // absorbs eth_tx back-pressure
    axis_fifo #(
        .payload_t (beat_t),
        .DEPTH     (FIFO_DEPTH)
    ) upstream_fifo (
        .axis_clk  (axis_clk),
        .rst       (rst),
        .in_data   (sync_beat),
        .in_valid  (sync_valid),
        .in_ready  (sync_ready),
        .out_data  ({eth_tx_data, eth_tx_last}),  // beat split to loose ports
        .out_valid (eth_tx_valid),
        .out_ready (eth_tx_ready)
    );

endmodule

//--- include/pon_bridge_tb_checks.svh
`ifndef PON_BRIDGE_TB_CHECKS_SVH
`define PON_BRIDGE_TB_CHECKS_SVH

////////////////////////////////////////////////////////////////////////////
// typed compares
////////////////////////////////////////////////////////////////////////////

task automatic check_pon_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
        $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        err_count++;
    end
endtask

task automatic check_eth_beat(input beat_t got, input beat_t exp, input string what);
    if (got !== exp) begin
        $display("Fail %0t: %s got %h last %b expected %h last %b",
                 $time, what, got.data, got.last, exp.data, exp.last);
        err_count++;
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
        err_count++;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// bounded waits, ready set on the rising edge and sampled mid cycle
////////////////////////////////////////////////////////////////////////////

function automatic logic ready_draw(input bit bp);
    integer v;
    v = $random(seed);       // drawn every call, keeps the stream fixed
    return bp ? v[0] : 1'b1;
endfunction

task automatic wait_eth_rx_accept();
    int n;
    n = 0;
    do begin
        @(negedge axis_clk);
        n++;
    end while (!eth_rx_ready && n < WAIT_LIMIT && timeout_count == 0);
    if (!eth_rx_ready) begin
        $display("timed out waiting for eth_rx_ready");
        timeout_count++;
    end
endtask

task automatic wait_pon_beat(input bit bp, output word_t got);
    int n;
    n = 0;
    do begin
        @(posedge axis_clk);
        pon_tx_ready <= ready_draw(bp);
        @(negedge axis_clk);
        n++;
    end while (!(pon_tx_valid && pon_tx_ready) && n < WAIT_LIMIT && timeout_count == 0);
    got = pon_tx_data;   // transfers on the coming edge
    if (!(pon_tx_valid && pon_tx_ready)) begin
        $display("timed out waiting for a beat on pon_tx");
        timeout_count++;
    end
endtask

task automatic wait_eth_beat(input bit bp, output beat_t got);
    int n;
    n = 0;
    do begin
        @(posedge axis_clk);
        eth_tx_ready <= ready_draw(bp);
        @(negedge axis_clk);
        n++;
    end while (!(eth_tx_valid && eth_tx_ready) && n < WAIT_LIMIT && timeout_count == 0);
    got = '{data: eth_tx_data, last: eth_tx_last};
    if (!(eth_tx_valid && eth_tx_ready)) begin
        $display("timed out waiting for a beat on eth_tx");
        timeout_count++;
    end
endtask

// eth_tx must stay quiet until the burst is over plus a short drain
task automatic watch_eth_idle(input bit bp, input int c);
    int n;
    int tail;   // cycles seen after the burst ended
    n = 0;
    tail = 0;
    while (tail < 3 && n < WAIT_LIMIT && timeout_count == 0) begin
        @(posedge axis_clk);
        eth_tx_ready <= ready_draw(bp);
        @(negedge axis_clk);
        check_flag(eth_tx_valid, 1'b0, $sformatf("case %0d eth_tx_valid, burst dropped", c));
        if (up_done) begin
            tail++;
        end
        n++;
    end
    if (n >= WAIT_LIMIT) begin
        $display("timed out waiting for the dropped burst to end");
        timeout_count++;
    end
endtask

`endif

//--- verif/pon_bridge_tb.sv
module pon_bridge_tb
    import pon_bridge_pkg::*;
();

    localparam int    NUM_CASES  = 9;
    localparam int    WAIT_LIMIT = 2000;            // cycles per handshake
    localparam word_t SYNC_REF   = 32'h0556_0556;   // burst preamble of the link

    typedef struct {
        int len;      // payload words
        int flips;    // bits inverted in the upstream sync word
        bit deliver;  // upstream burst should reach eth_tx
        bit bp;       // random ready on both sinks
    } frame_case_t;

    logic  axis_clk;
    logic  rst;
    word_t eth_rx_data;
    logic  eth_rx_last;
    logic  eth_rx_valid;
    logic  eth_rx_ready;
    word_t pon_tx_data;
    logic  pon_tx_valid;
    logic  pon_tx_ready;
    word_t pon_rx_data;
    logic  pon_rx_valid;
    word_t eth_tx_data;
    logic  eth_tx_last;
    logic  eth_tx_valid;
    logic  eth_tx_ready;
    logic  sync_overflow;

    integer      seed;
    int          err_count;
    int          timeout_count;
    bit          up_done;              // upstream burst fully driven
    frame_case_t cases [NUM_CASES];
    word_t       dn_words [$];         // ethernet payload of the case
    word_t       up_words [$];         // pon payload of the case

    `include "pon_bridge_tb_checks.svh"

    pon_bridge_top uut (.*);   // port names match one to one

    always #20 axis_clk = ~axis_clk;

    ////////////////////////////////////////////////////////////////////////////
    // per case drivers and collectors, all four run side by side
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_eth_frame(input int c);
        for (int i = 0; i < cases[c].len; i++) begin
            @(posedge axis_clk);
            eth_rx_valid <= 1'b1;
            eth_rx_data  <= dn_words[i];
            eth_rx_last  <= (i == cases[c].len - 1);
            wait_eth_rx_accept();
        end
        @(posedge axis_clk);
        eth_rx_valid <= 1'b0;
        eth_rx_last  <= 1'b0;
    endtask

    task automatic drive_pon_word(input word_t w);
        @(posedge axis_clk);
        pon_rx_valid <= 1'b1;   // line has no ready
        pon_rx_data  <= w;
    endtask

    task automatic send_pon_frame(input int c);
        word_t mask;
        mask = '0;
        for (int b = 0; b < cases[c].flips; b++) begin
            mask = mask | (word_t'(1) << ((b * 5) % 32));   // distinct bit positions
        end
        drive_pon_word(SYNC_REF ^ mask);
        drive_pon_word({16'(c), 16'(cases[c].len)});
        foreach (up_words[i]) begin
            drive_pon_word(up_words[i]);
        end
        repeat (2) drive_pon_word('0);   // idle words, far from the sync word
        @(posedge axis_clk);
        pon_rx_valid <= 1'b0;
        up_done = 1'b1;
    endtask

    task automatic collect_pon_frame(input int c);
        word_t exp [$];
        word_t got;
        exp.push_back(SYNC_REF);
        exp.push_back({16'(c), 16'(cases[c].len)});   // seq follows the case index
        foreach (dn_words[i]) begin
            exp.push_back(dn_words[i]);
        end
        foreach (exp[k]) begin
            wait_pon_beat(cases[c].bp, got);
            check_pon_word(got, exp[k], $sformatf("case %0d pon_tx beat %0d", c, k));
        end
    endtask

    task automatic collect_eth_frame(input int c);
        beat_t got;
        beat_t exp;
        if (cases[c].deliver) begin
            foreach (up_words[i]) begin
                wait_eth_beat(cases[c].bp, got);
                exp = '{data: up_words[i], last: (i == cases[c].len - 1)};
                check_eth_beat(got, exp, $sformatf("case %0d eth_tx word %0d", c, i));
            end
        end else begin
            watch_eth_idle(cases[c].bp, c);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed          = 32'h6205_fdb3;
        err_count     = 0;
        timeout_count = 0;
        up_done       = 1'b0;
        axis_clk      = 1'b0;
        rst           = 1'b1;
        eth_rx_data   = '0;
        eth_rx_last   = 1'b0;
        eth_rx_valid  = 1'b0;
        pon_tx_ready  = 1'b0;
        pon_rx_data   = '0;
        pon_rx_valid  = 1'b0;
        eth_tx_ready  = 1'b0;

        // len, flips, deliver, back-pressure
        cases[0] = '{4, 0, 1'b1, 1'b0};
        cases[1] = '{1, 3, 1'b1, 1'b0};
        cases[2] = '{16, 5, 1'b1, 1'b1};    // at the threshold
        cases[3] = '{8, 6, 1'b0, 1'b0};     // one bit over
        cases[4] = '{12, 0, 1'b1, 1'b1};    // good burst after a drop
        cases[5] = '{256, 2, 1'b1, 1'b1};   // largest legal payload
        cases[6] = '{7, 9, 1'b0, 1'b1};
        cases[7] = '{33, 4, 1'b1, 1'b1};
        cases[8] = '{64, 1, 1'b1, 1'b0};

        repeat (4) @(posedge axis_clk);
        rst <= 1'b0;
        @(negedge axis_clk);
        check_flag(pon_tx_valid, 1'b0, "pon_tx_valid after reset");
        check_flag(eth_tx_valid, 1'b0, "eth_tx_valid after reset");
        check_flag(sync_overflow, 1'b0, "sync_overflow after reset");

        for (int c = 0; c < NUM_CASES; c++) begin
            dn_words.delete();
            up_words.delete();
            for (int i = 0; i < cases[c].len; i++) begin
                dn_words.push_back($random(seed));
                up_words.push_back($random(seed));
            end
            up_done = 1'b0;
            fork
                send_eth_frame(c);
                collect_pon_frame(c);
                send_pon_frame(c);
                collect_eth_frame(c);
            join
        end

        // drain, then both sinks must be idle
        @(posedge axis_clk);
        pon_tx_ready <= 1'b1;
        eth_tx_ready <= 1'b1;
        repeat (4) @(posedge axis_clk);
        @(negedge axis_clk);
        check_flag(pon_tx_valid, 1'b0, "pon_tx_valid at end");
        check_flag(eth_tx_valid, 1'b0, "eth_tx_valid at end");
        check_flag(sync_overflow, 1'b0, "sync_overflow at end");

        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
src/pon_bridge_pkg.sv
src/axis_fifo.sv
src/pon_frame_builder.sv
src/pon_frame_sync.sv
src/pon_bridge_top.sv
verif/pon_bridge_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := pon_bridge_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/pon_bridge_tb_checks.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
